// ==== Bender.yml ====
package:
  name: pea

sources:
  - pea_isa_pkg.sv
  - pea_status_pkg.sv
  - pea_fifo_rd_if.sv
  - pea_fifo.sv
  - pea_firing_fsm.sv
  - pea_top.sv
  - target: test
    files:
      - pea_clk_gen.sv
      - pea_checker.sv
      - pea_tb.sv

// ==== pea.f ====
pea_isa_pkg.sv
pea_status_pkg.sv
pea_fifo_rd_if.sv
pea_fifo.sv
pea_firing_fsm.sv
pea_top.sv
pea_clk_gen.sv
pea_checker.sv
pea_tb.sv

// ==== pea_cases.txt ====
# C n t.. writes n command tokens and D n t.. writes n data tokens, all in hex.
# I again result status invokes once, N cmd_count data_count cmd_full data_full.
N 0 0 0 0
# Invoke with no command stored.
I 0 00000000 00000001
# SUM of four tokens without shift.
C 1 0160
D 4 0005 0003 fffe 000a
I 0 00000010 00000100
# SUMSQ of three tokens shifted by 3.
C 1 0243
D 3 0010 fff0 0003
I 0 00000041 00000200
# MAX of a single negative token.
C 1 0300
D 1 8000
I 0 ffff8000 00000300
# MAX of eight tokens shifted by 3.
C 1 03e3
D 8 fff0 ff00 0020 7fff 0100 ffff 1234 0000
I 0 00000fff 00000300
# SUM of eight negative tokens shifted by 3 rounds towards minus infinity.
C 1 01e3
D 8 8000 8000 8000 8000 ffff ffff ffff ffff
I 0 ffffbfff 00000100
N 0 0 0 0
# Unknown opcode and then a command that needs three of two stored tokens.
C 2 0700 0140
D 2 0001 0002
I 0 00000000 00000702
I 0 00000000 00000103
N 0 2 0 0
C 1 0121
I 0 00000001 00000100
# A second invoke while busy is ignored and the queued commands keep their order.
C 2 0100 0120
D 3 0007 0001 0002
I 1 00000007 00000100
N 1 2 0 0
I 0 00000003 00000100
# Both FIFOs are written past their depth of sixteen.
C 9 02e0 03e0 0100 0100 0100 0100 0100 0100 0100
C 8 0100 0100 0100 0100 0100 0100 0100 0100
D 9 0001 0002 0003 0004 0005 0006 0007 0008 0009
D 9 000a 000b 000c 000d 000e 000f 0010 7fff 7fff
N 10 10 1 1
I 0 000000cc 00000200
I 0 00000010 00000300
N e 0 0 0
I 0 00000000 00000103
N d 0 0 0

// ==== pea_checker.sv ====
// **************************************************************************
// Concurrent assertions on the PEA output strobes, bound to the top level.
// **************************************************************************

`timescale 1ns/1ps
`default_nettype none

module pea_checker (
    input wire logic        clk,
    input wire logic        rst_n,
    input wire logic        fc,         // Firing complete.
    input wire logic        result_wr,  // Result strobe.
    input wire logic [31:0] result,
    input wire logic [31:0] status
);

    // The result strobe and firing complete are one and the same pulse.
    strobe_is_fc: assert property (@(posedge clk) disable iff (!rst_n)
        result_wr == fc)
        else $error("result_wr differs from fc");

    // A firing lasts at least two cycles, so fc never repeats back to back.
    fc_single: assert property (@(posedge clk) disable iff (!rst_n)
        fc |=> !fc)
        else $error("fc was high on two cycles in a row");

    // Result and status must be fully known while they are strobed out.
    result_known: assert property (@(posedge clk) disable iff (!rst_n)
        result_wr |-> !$isunknown({result, status}))
        else $error("result or status has unknown bits while result_wr is high");

endmodule : pea_checker

// Attach the checker to every instance of the top level.
bind pea_top pea_checker strobe_checker (
    .clk       (clk),
    .rst_n     (rst_n),
    .fc        (fc),
    .result_wr (result_wr),
    .result    (result),
    .status    (status)
);

`default_nettype wire

// ==== pea_clk_gen.sv ====
// **************************************************************************
// Testbench clock and reset generator for the PEA.
// **************************************************************************

`timescale 1ns/1ps
`default_nettype none

module pea_clk_gen (
    output logic clk,    // Free-running 8 ns clock.
    output logic rst_n   // Synchronous active-low reset.
);

    initial
    begin
        clk = 1'b0;
        forever #4 clk = ~clk;  // Half period of 4 ns.
    end

    // Reset is held for ten rising edges and released on a falling edge.
    initial
    begin
        rst_n = 1'b0;
        repeat (10) @(posedge clk);
        @(negedge clk);
        rst_n = 1'b1;
    end

endmodule : pea_clk_gen

`default_nettype wire

// ==== pea_fifo.sv ====
// **************************************************************************
// Synchronous first-word-fall-through FIFO for one kind of PEA input token.
// **************************************************************************

`timescale 1ns/1ps
`default_nettype none

module pea_fifo #(
    parameter type payload_t   = logic [15:0],  // Token type stored in the buffer.
    parameter int  buffer_size = 16             // Number of entries, a power of two.
) (
    input  wire logic     clk,
    input  wire logic     rst_n,
    input  wire logic     wr,       // Host write strobe.
    input  wire payload_t wr_data,  // Token to store.
    output logic          full,     // No free entry left.
    pea_fifo_rd_if.fifo   rd        // Read side towards the firing FSM.
);

    localparam int addr_w  = $clog2(buffer_size);
    localparam int count_w = addr_w + 1;

    // ***********************************************************************
    // Storage and pointers
    // ***********************************************************************

    payload_t           mem [buffer_size];  // Circular buffer.
    logic [addr_w-1:0]  wr_ptr_q;           // Next entry to write.
    logic [addr_w-1:0]  rd_ptr_q;           // Entry at the head.
    logic [count_w-1:0] count_q;            // Occupancy.

    logic do_wr;  // Write that is actually stored.
    logic do_rd;  // Pop that is actually performed.

    assign full  = (count_q == count_w'(buffer_size));
    assign do_wr = wr && !full;                // A write into a full FIFO is dropped.
    assign do_rd = rd.rd_en && (count_q != '0); // Guard against a stray pop when empty.

    // Pointers wrap on their own since the depth is a power of two.
    always_ff @(posedge clk)
    begin
        if (!rst_n)
        begin
            wr_ptr_q <= '0;
            rd_ptr_q <= '0;
            count_q  <= '0;
        end
        else
        begin
            if (do_wr)
                wr_ptr_q <= wr_ptr_q + 1'b1;
            if (do_rd)
                rd_ptr_q <= rd_ptr_q + 1'b1;
            // A simultaneous read and write leaves the occupancy unchanged.
            if (do_wr && !do_rd)
                count_q <= count_q + 1'b1;
            else if (do_rd && !do_wr)
                count_q <= count_q - 1'b1;
        end
    end

    // The data array itself is plain storage.
    always_ff @(posedge clk)
    begin
        if (do_wr)
            mem[wr_ptr_q] <= wr_data;  // Visible at the head from this edge on.
    end

    // ***********************************************************************
    // Read side
    // ***********************************************************************

    // The head falls through combinationally, so the reader sees the token
    // in the same cycle in which it decides to pop.
    assign rd.token = mem[rd_ptr_q];
    assign rd.count = count_q;
    assign rd.empty = (count_q == '0);

endmodule : pea_fifo

`default_nettype wire

// ==== pea_fifo_rd_if.sv ====
// **************************************************************************
// Read side of a PEA input FIFO, with modports for the FIFO and its reader.
// **************************************************************************

`timescale 1ns/1ps
`default_nettype none

interface pea_fifo_rd_if #(
    parameter type payload_t   = logic [15:0],  // Token type carried by the FIFO.
    parameter int  buffer_size = 16             // Depth of the FIFO, a power of two.
);

    // The count needs one bit more than the address to reach buffer_size.
    localparam int count_w = $clog2(buffer_size) + 1;

    logic               rd_en;  // Pop request from the reader.
    payload_t           token;  // Head of the FIFO, valid while empty is low.
    logic [count_w-1:0] count;  // Number of stored tokens.
    logic               empty;  // No token stored.

    // The FIFO owns the data and the levels.
    modport fifo (
        input  rd_en,
        output token,
        output count,
        output empty
    );

    // The reader only pops. It must not raise rd_en while empty is high.
    modport reader (
        output rd_en,
        input  token,
        input  count,
        input  empty
    );

endinterface : pea_fifo_rd_if

`default_nettype wire

// ==== pea_firing_fsm.sv ====
// **************************************************************************
// Firing FSM of the PEA: fetches and checks a command, reads its data
// tokens, accumulates and emits the result with its status word.
// **************************************************************************

`timescale 1ns/1ps
`default_nettype none

module pea_firing_fsm
    import pea_isa_pkg::*;
    import pea_status_pkg::*;
(
    input  wire logic                     clk,
    input  wire logic                     rst_n,
    input  wire logic                     start,      // One-cycle firing request.
    pea_fifo_rd_if.reader                 cmd_rd,     // Command FIFO read side.
    pea_fifo_rd_if.reader                 data_rd,    // Data FIFO read side.
    output logic                          result_wr,  // Result and status strobe.
    output logic [result_size_c-1:0]      result,     // Shifted accumulator.
    output logic [result_size_c-1:0]      status,     // Status word.
    output logic                          fc          // Firing complete.
);

    // ***********************************************************************
    // State and datapath registers
    // ***********************************************************************

    typedef enum logic [2:0] {
        s_idle,   // Waiting for start.
        s_fetch,  // Pop and latch a command.
        s_check,  // Validate opcode and data population.
        s_read,   // Pop and fold one data token per cycle.
        s_emit    // Present result and status for one cycle.
    } fire_state_t;

    fire_state_t state_q;

    pea_cmd_t                        cmd_q;     // Latched command, zero if none popped.
    pea_status_code_t                code_q;    // Outcome of this firing.
    logic [2:0]                      remain_q;  // Tokens left to read, minus one.
    logic                            first_q;   // Next token is the first one.
    logic signed [result_size_c-1:0] acc_q;     // Running result.

    logic signed [result_size_c-1:0] tok_ext;   // Sign-extended head data token.
    logic signed [result_size_c-1:0] tok_sq;    // Square of the head data token.
    logic signed [result_size_c-1:0] acc_next;  // Accumulator after folding the head.
    logic                            op_known;  // Latched opcode is supported.
    logic                            too_few;   // Fewer data tokens stored than needed.
    pea_status_word_t                status_w;

    // ***********************************************************************
    // Command checks
    // ***********************************************************************

    assign op_known = (cmd_q.opcode == op_sum)
                   || (cmd_q.opcode == op_sumsq)
                   || (cmd_q.opcode == op_max);

    // The command asks for arg1 plus one tokens.
    assign too_few = int'(data_rd.count) < (int'(cmd_q.arg1) + 1);

    // ***********************************************************************
    // Accumulator update
    // ***********************************************************************

    always_comb
    begin
        tok_ext = result_size_c'(data_rd.token);  // Size cast keeps the sign.
        tok_sq  = tok_ext * tok_ext;
        case (cmd_q.opcode)
            op_sum:   acc_next = acc_q + tok_ext;
            op_sumsq: acc_next = acc_q + tok_sq;
            op_max:   acc_next = (first_q || (tok_ext > acc_q)) ? tok_ext : acc_q;
            default:  acc_next = acc_q;  // Never reached in s_read.
        endcase
    end

    // ***********************************************************************
    // State register
    // ***********************************************************************

    always_ff @(posedge clk)
    begin
        if (!rst_n)
            state_q <= s_idle;
        else
        begin
            case (state_q)
                s_idle:
                    if (start)
                        state_q <= s_fetch;
                s_fetch:
                    // An empty command FIFO ends the firing right away.
                    state_q <= cmd_rd.empty ? s_emit : s_check;
                s_check:
                    state_q <= (!op_known || too_few) ? s_emit : s_read;
                s_read:
                    if (remain_q == '0)
                        state_q <= s_emit;  // Last token folded in this cycle.
                s_emit:
                    state_q <= s_idle;
                default:
                    state_q <= s_idle;
            endcase
        end
    end

    // ***********************************************************************
    // Datapath
    // ***********************************************************************

    always_ff @(posedge clk)
    begin
        case (state_q)
            s_fetch:
            begin
                acc_q <= '0;  // Error firings report a zero result.
                if (cmd_rd.empty)
                begin
                    cmd_q  <= '0;  // Opcode field and shift both read as zero.
                    code_q <= st_no_command;
                end
                else
                    cmd_q <= cmd_rd.token;
            end
            s_check:
            begin
                remain_q <= cmd_q.arg1;
                first_q  <= 1'b1;
                if (!op_known)
                    code_q <= st_bad_opcode;
                else if (too_few)
                    code_q <= st_underflow;  // Data stays in the FIFO.
                else
                    code_q <= st_ok;
            end
            s_read:
            begin
                acc_q    <= acc_next;
                remain_q <= remain_q - 1'b1;
                first_q  <= 1'b0;
            end
            default:
            begin
                // Hold everything between firings.
            end
        endcase
    end

    // ***********************************************************************
    // Outputs
    // ***********************************************************************

    // Pops are decoded from the state so that they are low after reset.
    assign cmd_rd.rd_en  = (state_q == s_fetch) && !cmd_rd.empty;
    assign data_rd.rd_en = (state_q == s_read);  // Population was checked before.

    assign fc        = (state_q == s_emit);
    assign result_wr = fc;                        // Same pulse as firing complete.

    assign result = acc_q >>> cmd_q.arg2;         // Arithmetic shift keeps the sign.

    assign status_w.reserved = '0;
    assign status_w.opcode   = cmd_q.opcode;
    assign status_w.code     = code_q;
    assign status            = status_w;

endmodule : pea_firing_fsm

`default_nettype wire

// ==== pea_isa_pkg.sv ====
// **************************************************************************
// Instruction set of the PEA: word widths, command token layout, opcodes
// and the signed data token type.
// **************************************************************************

`default_nettype none

package pea_isa_pkg;

    // **********************************************************************
    // Word widths
    // **********************************************************************

    localparam int word_size_c   = 16;                // Width of every input token.
    localparam int result_size_c = 2 * word_size_c;   // Result and status are double width.

    // **********************************************************************
    // Command token
    // **********************************************************************

    // The opcode sits in the upper byte, so a command reads as 0xOOAA in hex
    // where AA packs arg1 and arg2 together.
    typedef struct packed {
        logic [7:0] opcode;  // Operation to perform.
        logic [2:0] arg1;    // Number of data tokens to read, minus one.
        logic [4:0] arg2;    // Arithmetic right shift on the final result.
    } pea_cmd_t;

    // Supported operations. Anything else is rejected by the firing FSM.
    localparam logic [7:0] op_sum   = 8'h01;  // Sum of the tokens.
    localparam logic [7:0] op_sumsq = 8'h02;  // Sum of the squared tokens.
    localparam logic [7:0] op_max   = 8'h03;  // Largest token.

    // **********************************************************************
    // Data token
    // **********************************************************************

    // Data tokens are two's complement.
    typedef logic signed [word_size_c-1:0] pea_data_t;

endpackage : pea_isa_pkg

`default_nettype wire

// ==== pea_status_pkg.sv ====
// **************************************************************************
// Status codes of a firing and the layout of the 32-bit status word.
// **************************************************************************

`default_nettype none

package pea_status_pkg;

    // Outcome of one firing. The code is the low byte of the status word.
    typedef enum logic [7:0] {
        st_ok         = 8'd0,  // Firing completed normally.
        st_no_command = 8'd1,  // The command FIFO was empty at invoke.
        st_bad_opcode = 8'd2,  // The popped command had an unknown opcode.
        st_underflow  = 8'd3   // Too few data tokens were stored.
    } pea_status_code_t;

    // The status word as it leaves the element. The opcode field is zero
    // when no command was popped.
    typedef struct packed {
        logic [15:0]      reserved;  // Always zero.
        logic [7:0]       opcode;    // Opcode of the popped command.
        pea_status_code_t code;      // Outcome code.
    } pea_status_word_t;

endpackage : pea_status_pkg

`default_nettype wire

// ==== pea_tb.sv ====
// **************************************************************************
// PEA testbench: replays the cases file and compares results and counts.
// **************************************************************************

`timescale 1ns/1ps
`default_nettype none

module pea_tb;

    localparam int buffer_size = 16;
    localparam int fc_timeout  = 40;  // The longest firing takes eleven cycles.
    localparam int rst_timeout = 40;

    logic        clk;
    logic        rst_n;
    logic        invoke;
    logic        cmd_wr;
    logic [15:0] cmd_in;
    logic        data_wr;
    logic [15:0] data_in;
    logic        cmd_full;
    logic        data_full;
    logic [$clog2(buffer_size):0] cmd_count;
    logic [$clog2(buffer_size):0] data_count;
    logic        busy;
    logic        fc;
    logic        result_wr;
    logic [31:0] result;
    logic [31:0] status;

    int           fd;          // Handle of the cases file.
    int           cycles;
    logic         done;
    logic [7:0]   kind;        // Record kind letter.
    logic [959:0] line;        // Rest of a comment line.
    logic [31:0]  f0;
    logic [31:0]  f1;
    logic [31:0]  f2;
    logic [31:0]  f3;

    pea_clk_gen clk_gen (
        .clk   (clk),
        .rst_n (rst_n)
    );

    pea_top #(
        .buffer_size (buffer_size)
    ) uut (
        .clk        (clk),
        .rst_n      (rst_n),
        .invoke     (invoke),
        .cmd_wr     (cmd_wr),
        .cmd_in     (cmd_in),
        .data_wr    (data_wr),
        .data_in    (data_in),
        .cmd_full   (cmd_full),
        .data_full  (data_full),
        .cmd_count  (cmd_count),
        .data_count (data_count),
        .busy       (busy),
        .fc         (fc),
        .result_wr  (result_wr),
        .result     (result),
        .status     (status)
    );

    // **********************************************************************
    // Helper tasks
    // **********************************************************************

    task automatic abort_run(input string what);
        $display("%s", what);
        $display("Verification failed");
        $fatal(1);
    endtask

    // Case equality, so unknown bits count as a mismatch.
    task automatic check_value(input string name, input logic [31:0] got,
                               input logic [31:0] expected);
        if (got !== expected)
        begin
            $display("mismatch %s: got 0x%h, expected 0x%h", name, got, expected);
            $display("Verification failed");
            $fatal(1);
        end
    endtask

    task automatic read_hex(output logic [31:0] value);
        int got;
        got = $fscanf(fd, "%h", value);
        if (got != 1)
            abort_run("the cases file ended in the middle of a record");
    endtask

    // Writes n tokens on back-to-back cycles, then drops the strobe.
    task automatic write_tokens(input logic to_cmd);
        logic [31:0] n;
        logic [31:0] value;
        read_hex(n);
        for (int i = 0; i < n; i++)
        begin
            read_hex(value);
            @(negedge clk);
            cmd_wr  = to_cmd;
            data_wr = !to_cmd;
            if (to_cmd)
                cmd_in = value[15:0];
            else
                data_in = value[15:0];
        end
        @(negedge clk);
        cmd_wr  = 1'b0;
        data_wr = 1'b0;
    endtask

    // One invoke pulse; with again set a second pulse lands while busy.
    task automatic run_invoke(input logic again, input logic [31:0] exp_result,
                              input logic [31:0] exp_status);
        int   waited;
        logic seen;
        waited = 0;
        seen   = 1'b0;
        @(negedge clk);
        invoke = 1'b1;
        while (!seen)
        begin
            @(negedge clk);
            invoke = again && (waited == 1);  // The controller is in its wait state here.
            waited++;
            check_value("busy", busy, 1'b1);  // High from the cycle after invoke until fc.
            if (fc === 1'b1)
                seen = 1'b1;
            else if (waited > fc_timeout)
                abort_run("fc never arrived after an invoke");
        end
        invoke = 1'b0;
        check_value("result_wr", result_wr, 1'b1);
        check_value("result", result, exp_result);
        check_value("status", status, exp_status);
        // The controller must be back in idle with no second firing under way.
        @(negedge clk);
        check_value("busy", busy, 1'b0);
        check_value("fc", fc, 1'b0);
    endtask

    // **********************************************************************
    // Main sequence
    // **********************************************************************

    initial
    begin
        invoke  = 1'b0;
        cmd_wr  = 1'b0;
        cmd_in  = '0;
        data_wr = 1'b0;
        data_in = '0;
        fd = $fopen("pea_cases.txt", "r");
        if (fd == 0)
            abort_run("could not open the cases file pea_cases.txt");
        cycles = 0;
        while (rst_n !== 1'b1)
        begin
            @(negedge clk);
            cycles++;
            if (cycles > rst_timeout)
                abort_run("reset was never released");
        end
        done = 1'b0;
        while (!done)
        begin
            if ($fscanf(fd, " %c", kind) != 1)
                done = 1'b1;  // End of the file.
            else
            begin
                case (kind)
                    "#": f0 = $fgets(line, fd);  // Skip a comment line.
                    "C": write_tokens(1'b1);
                    "D": write_tokens(1'b0);
                    "I":
                    begin
                        read_hex(f0);
                        read_hex(f1);
                        read_hex(f2);
                        run_invoke(f0[0], f1, f2);
                    end
                    "N":
                    begin
                        read_hex(f0);
                        read_hex(f1);
                        read_hex(f2);
                        read_hex(f3);
                        @(negedge clk);
                        check_value("cmd_count", cmd_count, f0);
                        check_value("data_count", data_count, f1);
                        check_value("cmd_full", cmd_full, f2);
                        check_value("data_full", data_full, f3);
                    end
                    default: abort_run("the cases file holds an unknown record kind");
                endcase
            end
        end
        $fclose(fd);
        $display("Verification passed");
        $finish;
    end

endmodule : pea_tb

`default_nettype wire

// ==== pea_top.sv ====
// **************************************************************************
// PEA top level: invoke FSM, command and data input FIFOs, firing FSM.
// **************************************************************************

`timescale 1ns/1ps
`default_nettype none

module pea_top
    import pea_isa_pkg::*;
#(
    parameter int buffer_size = 16  // Depth of each input FIFO, a power of two.
) (
    input  wire logic                         clk,
    input  wire logic                         rst_n,
    input  wire logic                         invoke,      // Scheduler firing request.
    input  wire logic                         cmd_wr,      // Host command write strobe.
    input  wire logic [word_size_c-1:0]       cmd_in,      // Command token.
    input  wire logic                         data_wr,     // Host data write strobe.
    input  wire logic [word_size_c-1:0]       data_in,     // Data token.
    output logic                              cmd_full,
    output logic                              data_full,
    output logic [$clog2(buffer_size):0]      cmd_count,   // Command population.
    output logic [$clog2(buffer_size):0]      data_count,  // Data population.
    output logic                              busy,        // A firing is in progress.
    output logic                              fc,          // Firing complete.
    output logic                              result_wr,
    output logic [2*word_size_c-1:0]          result,
    output logic [2*word_size_c-1:0]          status
);

    // ***********************************************************************
    // Input FIFOs
    // ***********************************************************************

    pea_fifo_rd_if #(.payload_t(pea_cmd_t),  .buffer_size(buffer_size)) cmd_rd ();
    pea_fifo_rd_if #(.payload_t(pea_data_t), .buffer_size(buffer_size)) data_rd ();

    pea_fifo #(
        .payload_t   (pea_cmd_t),
        .buffer_size (buffer_size)
    ) cmd_fifo (
        .clk     (clk),
        .rst_n   (rst_n),
        .wr      (cmd_wr),
        .wr_data (pea_cmd_t'(cmd_in)),
        .full    (cmd_full),
        .rd      (cmd_rd)
    );

    pea_fifo #(
        .payload_t   (pea_data_t),
        .buffer_size (buffer_size)
    ) data_fifo (
        .clk     (clk),
        .rst_n   (rst_n),
        .wr      (data_wr),
        .wr_data (pea_data_t'(data_in)),
        .full    (data_full),
        .rd      (data_rd)
    );

    // The scheduler sees the occupancies as the token populations.
    assign cmd_count  = cmd_rd.count;
    assign data_count = data_rd.count;

    // ***********************************************************************
    // Invoke FSM
    // ***********************************************************************

    typedef enum logic [1:0] {
        inv_idle,          // Ready for an invoke.
        inv_firing_start,  // Issue the start pulse.
        inv_firing_wait    // Wait for the firing to complete.
    } invoke_state_t;

    invoke_state_t inv_state_q;
    logic          start;  // One-cycle start towards the firing FSM.

    always_ff @(posedge clk)
    begin
        if (!rst_n)
            inv_state_q <= inv_idle;
        else
        begin
            case (inv_state_q)
                inv_idle:
                    if (invoke)
                        inv_state_q <= inv_firing_start;
                inv_firing_start:
                    inv_state_q <= inv_firing_wait;
                inv_firing_wait:
                    if (fc)
                        inv_state_q <= inv_idle;  // Invokes seen until here are dropped.
                default:
                    inv_state_q <= inv_idle;
            endcase
        end
    end

    assign start = (inv_state_q == inv_firing_start);
    assign busy  = (inv_state_q != inv_idle);

    // ***********************************************************************
    // Firing FSM
    // ***********************************************************************

    pea_firing_fsm firing_fsm (
        .clk       (clk),
        .rst_n     (rst_n),
        .start     (start),
        .cmd_rd    (cmd_rd),
        .data_rd   (data_rd),
        .result_wr (result_wr),
        .result    (result),
        .status    (status),
        .fc        (fc)
    );

endmodule : pea_top

`default_nettype wire
